// File: src/sata_tl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, FIFO sizing, fill thresholds and entry type codes
// for the SATA transport buffers. Modules refer to these by
// scoped names only.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sata_tl_pkg;

    localparam int fifo_addr_w = 9;                 // 512 words per FIFO
    localparam int fifo_depth  = 1 << fifo_addr_w;
    localparam int word_w      = 32;                // one dword
    localparam int type_w      = 2;                 // entry tag bits
    localparam int entry_w     = type_w + word_w;   // tag on top, data below

    typedef logic [fifo_addr_w-1:0] fifo_addr_t;
    typedef logic [fifo_addr_w:0]   fifo_fill_t;    // 0..512 inclusive
    typedef logic [word_w-1:0]      word_t;
    typedef logic [type_w-1:0]      h2d_type_t;
    typedef logic [type_w-1:0]      d2h_type_t;
    typedef logic [entry_w-1:0]     fifo_entry_t;

    // host -> device tags
    localparam h2d_type_t h2d_fis_data = 2'd0;
    localparam h2d_type_t h2d_fis_head = 2'd1;
    localparam h2d_type_t h2d_fis_last = 2'd2;

    // device -> host tags, ok/err entries carry no useful data
    localparam d2h_type_t d2h_fis_data = 2'd0;
    localparam d2h_type_t d2h_fis_head = 2'd1;
    localparam d2h_type_t d2h_fis_ok   = 2'd2;
    localparam d2h_type_t d2h_fis_err  = 2'd3;

    localparam fifo_fill_t fifo_full_fill  = fifo_fill_t'(fifo_depth);
    localparam fifo_fill_t xmit_start_fill = 10'd64;  // start xmit before last word
    localparam fifo_fill_t h2d_room_limit  = 10'd504; // h2d_ready drops here
    localparam fifo_fill_t d2h_many_fill   = 10'd8;   // several dwords waiting
    localparam fifo_fill_t d2h_busy_fill   = 10'd63;  // tell link to hold off

endpackage

// File: src/fifo_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pointer and fill control for one same-clock FIFO in front of a
// two-stage registered memory. Presents first-word-fall-through
// output: nempty means the memory output register holds a word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fifo_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr,        // push one entry
    input  logic                    rd,        // consumer takes the output word
    output logic                    nempty,    // output register valid
    output sata_tl_pkg::fifo_fill_t fill,      // entries held, incl. pipeline
    output sata_tl_pkg::fifo_addr_t waddr,
    output sata_tl_pkg::fifo_addr_t raddr,
    output logic                    mem_re,    // latch array word
    output logic                    mem_regen  // move latch to output reg
);

    logic                    stage_valid;  // memory latch holds a word
    sata_tl_pkg::fifo_fill_t mem_words;    // still only in the array

    // words not yet pulled out of the array
    assign mem_words = fill
                     - sata_tl_pkg::fifo_fill_t'(stage_valid)
                     - sata_tl_pkg::fifo_fill_t'(nempty);

    // output reg free or emptied this cycle
    assign mem_regen = stage_valid && (!nempty || rd);
    // refill the latch when it is empty or moving on
    assign mem_re    = (mem_words != '0) && (!stage_valid || mem_regen);

    always_ff @(posedge clk) begin
        if (rst) begin
            waddr       <= '0;
            raddr       <= '0;
            fill        <= '0;
            stage_valid <= 1'b0;
            nempty      <= 1'b0;
        end else begin
            if (wr) begin
                waddr <= waddr + 1'b1;
            end
            if (mem_re) begin
                raddr <= raddr + 1'b1;
            end
            if (wr && !rd) begin
                fill <= fill + 1'b1;
            end else if (!wr && rd) begin
                fill <= fill - 1'b1;
            end
            if (mem_re) begin
                stage_valid <= 1'b1;   // new word in latch
            end else if (mem_regen) begin
                stage_valid <= 1'b0;   // drained to output
            end
            if (mem_regen) begin
                nempty <= 1'b1;
            end else if (rd) begin
                nempty <= 1'b0;        // last word taken
            end
        end
    end

    // writer must respect the fill thresholds upstream
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(wr && (fill == sata_tl_pkg::fifo_full_fill)))
        else $error("fifo_ctrl: write into a full FIFO");

    // consumer has to qualify its read with nempty
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd |-> nempty)
        else $error("fifo_ctrl: read while output is empty");

endmodule

// File: src/fifo_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port FIFO storage, one clock. Read side is two registered
// stages: re latches the array word, regen loads the output reg.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fifo_mem (
    input  logic                     clk,
    input  logic                     we,
    input  sata_tl_pkg::fifo_addr_t  waddr,
    input  sata_tl_pkg::fifo_entry_t wdata,
    input  sata_tl_pkg::fifo_addr_t  raddr,
    input  logic                     re,     // array read enable
    input  logic                     regen,  // output register enable
    output sata_tl_pkg::fifo_entry_t rdata
);

    sata_tl_pkg::fifo_entry_t mem [0:sata_tl_pkg::fifo_depth-1];
    sata_tl_pkg::fifo_entry_t latch_q;  // first read stage

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            latch_q <= mem[raddr];
        end
        if (regen) begin
            rdata <= latch_q;  // holds until next regen
        end
    end

endmodule

// File: src/h2d_frame_sched.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decides when the link may start an outgoing frame: after a FIS
// head, once the whole FIS or enough of it sits in the H2D FIFO.
// Issues a one-cycle ll_frame_req.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module h2d_frame_sched (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    h2d_valid,      // host writes an entry
    input  sata_tl_pkg::h2d_type_t  h2d_type,
    input  sata_tl_pkg::fifo_fill_t fill,           // h2d FIFO occupancy
    input  logic                    ll_frame_busy,  // link can't take a request
    output logic                    ll_frame_req
);

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_request
    } sched_state_t;

    sched_state_t state;
    logic         head_wr;   // FIS head going in
    logic         last_wr;   // FIS end going in
    logic         start_ok;

    assign head_wr  = h2d_valid && (h2d_type == sata_tl_pkg::h2d_fis_head);
    assign last_wr  = h2d_valid && (h2d_type == sata_tl_pkg::h2d_fis_last);
    // whole FIS in, or enough buffered to keep the link fed
    assign start_ok = !ll_frame_busy
                   && (last_wr || (fill >= sata_tl_pkg::xmit_start_fill));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (head_wr) begin
                        state <= st_collect;
                    end
                end
                st_collect: begin
                    if (start_ok) begin
                        state <= st_request;  // busy high keeps us waiting
                    end
                end
                st_request: begin
                    state <= st_idle;         // single pulse
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign ll_frame_req = (state == st_request);

    a_req_pulse: assert property (@(posedge clk) disable iff (rst)
        ll_frame_req |=> !ll_frame_req)
        else $error("h2d_frame_sched: frame request longer than one cycle");

endmodule

// File: src/d2h_fis_tagger.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tags words coming from the link for the D2H FIFO and appends
// one R_OK / R_ERR status entry when a received FIS ends.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module d2h_fis_tagger (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ll_d2h_valid,        // one word from link
    input  sata_tl_pkg::word_t       ll_d2h_data,
    input  logic                     ll_incom_start,      // pulse, FIS begins
    input  logic                     ll_incom_done,       // pulse, good end
    input  logic                     ll_incom_invalidate, // pulse, bad end
    output logic                     fifo_wr,
    output sata_tl_pkg::fifo_entry_t fifo_wdata
);

    sata_tl_pkg::d2h_type_t type_r;     // tag for the next entry
    logic                   status_r;   // push end-of-FIS entry
    sata_tl_pkg::word_t     last_word;  // filler data for status entry
    logic                   fis_end;

    assign fis_end = ll_incom_done || ll_incom_invalidate;

    always_ff @(posedge clk) begin
        if (rst || ll_incom_start) begin
            type_r <= sata_tl_pkg::d2h_fis_head;  // first word is the head
        end else if (ll_d2h_valid) begin
            type_r <= sata_tl_pkg::d2h_fis_data;
        end else if (fis_end) begin
            type_r <= ll_incom_invalidate ? sata_tl_pkg::d2h_fis_err
                                          : sata_tl_pkg::d2h_fis_ok;
        end

        if (rst) begin
            status_r <= 1'b0;
        end else begin
            // only once, and only if something arrived
            status_r <= fis_end && (type_r == sata_tl_pkg::d2h_fis_data);
        end
    end

    always_ff @(posedge clk) begin
        if (ll_d2h_valid) begin
            last_word <= ll_d2h_data;
        end
    end

    assign fifo_wr    = ll_d2h_valid || status_r;
    assign fifo_wdata = {type_r, (ll_d2h_valid ? ll_d2h_data : last_word)};

    // link must not end a FIS in the cycle that carries a word
    a_end_apart: assert property (@(posedge clk) disable iff (rst)
        fis_end |-> !ll_d2h_valid)
        else $error("d2h_fis_tagger: end pulse together with data word");

endmodule

// File: src/sata_tl_buffers.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transport-side buffers between the host and the SATA link layer.
// H2D FIFO with frame scheduler, D2H FIFO with FIS tagger.
// Link signals appear as ports of this top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sata_tl_buffers (
    input  logic                   clk,
    input  logic                   rst,
    // host -> device
    input  sata_tl_pkg::word_t     h2d_data,
    input  sata_tl_pkg::h2d_type_t h2d_type,      // data / head / last
    input  logic                   h2d_valid,
    output logic                   h2d_ready,     // room left in h2d FIFO
    output sata_tl_pkg::word_t     ll_h2d_data,
    output logic                   ll_h2d_last,
    output logic                   ll_h2d_valid,
    input  logic                   ll_h2d_strobe, // link takes the word
    output logic                   ll_frame_req,
    input  logic                   ll_frame_busy,
    // device -> host
    input  sata_tl_pkg::word_t     ll_d2h_data,
    input  logic                   ll_d2h_valid,
    output logic                   ll_d2h_busy,   // early back-pressure
    input  logic                   ll_incom_start,
    input  logic                   ll_incom_done,
    input  logic                   ll_incom_invalidate,
    output sata_tl_pkg::word_t     d2h_data,
    output sata_tl_pkg::d2h_type_t d2h_type,      // data / head / ok / err
    output logic                   d2h_valid,
    output logic                   d2h_many,
    input  logic                   d2h_ready
);

    sata_tl_pkg::fifo_addr_t  h2d_waddr, h2d_raddr;
    sata_tl_pkg::fifo_fill_t  h2d_fill;
    sata_tl_pkg::fifo_entry_t h2d_rdata;
    logic                     h2d_nempty, h2d_re, h2d_regen, h2d_rd;

    sata_tl_pkg::fifo_addr_t  d2h_waddr, d2h_raddr;
    sata_tl_pkg::fifo_fill_t  d2h_fill;
    sata_tl_pkg::fifo_entry_t d2h_wdata, d2h_rdata;
    logic                     d2h_nempty, d2h_re, d2h_regen, d2h_rd, d2h_wr;

    assign h2d_rd       = h2d_nempty && ll_h2d_strobe;  // strobe on a valid word
    assign ll_h2d_valid = h2d_nempty;
    assign ll_h2d_data  = h2d_rdata[sata_tl_pkg::word_w-1:0];
    assign ll_h2d_last  = (h2d_rdata[sata_tl_pkg::entry_w-1:sata_tl_pkg::word_w]
                           == sata_tl_pkg::h2d_fis_last);
    assign h2d_ready    = (h2d_fill < sata_tl_pkg::h2d_room_limit);

    assign d2h_rd      = d2h_nempty && d2h_ready;
    assign d2h_valid   = d2h_nempty;
    assign d2h_data    = d2h_rdata[sata_tl_pkg::word_w-1:0];
    assign d2h_type    = d2h_rdata[sata_tl_pkg::entry_w-1:sata_tl_pkg::word_w];
    assign d2h_many    = (d2h_fill >= sata_tl_pkg::d2h_many_fill);
    assign ll_d2h_busy = (d2h_fill >= sata_tl_pkg::d2h_busy_fill);  // link should pause

    fifo_ctrl u_h2d_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),
        .rd        (h2d_rd),
        .nempty    (h2d_nempty),
        .fill      (h2d_fill),
        .waddr     (h2d_waddr),
        .raddr     (h2d_raddr),
        .mem_re    (h2d_re),
        .mem_regen (h2d_regen)
    );

    fifo_mem u_h2d_mem (
        .clk   (clk),
        .we    (h2d_valid),
        .waddr (h2d_waddr),
        .wdata ({h2d_type, h2d_data}),
        .raddr (h2d_raddr),
        .re    (h2d_re),
        .regen (h2d_regen),
        .rdata (h2d_rdata)
    );

    h2d_frame_sched u_sched (
        .clk           (clk),
        .rst           (rst),
        .h2d_valid     (h2d_valid),
        .h2d_type      (h2d_type),
        .fill          (h2d_fill),
        .ll_frame_busy (ll_frame_busy),
        .ll_frame_req  (ll_frame_req)
    );

    d2h_fis_tagger u_tagger (
        .clk                 (clk),
        .rst                 (rst),
        .ll_d2h_valid        (ll_d2h_valid),
        .ll_d2h_data         (ll_d2h_data),
        .ll_incom_start      (ll_incom_start),
        .ll_incom_done       (ll_incom_done),
        .ll_incom_invalidate (ll_incom_invalidate),
        .fifo_wr             (d2h_wr),
        .fifo_wdata          (d2h_wdata)
    );

    fifo_ctrl u_d2h_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (d2h_wr),
        .rd        (d2h_rd),
        .nempty    (d2h_nempty),
        .fill      (d2h_fill),
        .waddr     (d2h_waddr),
        .raddr     (d2h_raddr),
        .mem_re    (d2h_re),
        .mem_regen (d2h_regen)
    );

    fifo_mem u_d2h_mem (
        .clk   (clk),
        .we    (d2h_wr),
        .waddr (d2h_waddr),
        .wdata (d2h_wdata),
        .raddr (d2h_raddr),
        .re    (d2h_re),
        .regen (d2h_regen),
        .rdata (d2h_rdata)
    );

endmodule

// File: bench/tb_sata_tl_buffers.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SATA transport buffers. Plays host and link,
// keeps scoreboards of the expected FIFO entries, checks levels
// with assertions and prints one line per test plus a summary.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_sata_tl_buffers;

    logic                   clk;
    logic                   rst;
    sata_tl_pkg::word_t     h2d_data;
    sata_tl_pkg::h2d_type_t h2d_type;
    logic                   h2d_valid;
    logic                   h2d_ready;
    sata_tl_pkg::word_t     ll_h2d_data;
    logic                   ll_h2d_last;
    logic                   ll_h2d_valid;
    logic                   ll_h2d_strobe;
    logic                   ll_frame_req;
    logic                   ll_frame_busy;
    sata_tl_pkg::word_t     ll_d2h_data;
    logic                   ll_d2h_valid;
    logic                   ll_d2h_busy;
    logic                   ll_incom_start;
    logic                   ll_incom_done;
    logic                   ll_incom_invalidate;
    sata_tl_pkg::word_t     d2h_data;
    sata_tl_pkg::d2h_type_t d2h_type;
    logic                   d2h_valid;
    logic                   d2h_many;
    logic                   d2h_ready;

    sata_tl_pkg::word_t      exp_h2d_data [$];  // link side scoreboard
    bit                      exp_h2d_last [$];
    sata_tl_pkg::word_t      exp_d2h_data [$];  // host side scoreboard
    sata_tl_pkg::d2h_type_t  exp_d2h_type [$];
    bit                      exp_d2h_chk  [$];  // 0 for status entries
    sata_tl_pkg::fifo_fill_t d2h_fill_model;    // expected d2h occupancy
    logic                    got_word;          // word seen since start
    logic                    status_due;        // status entry on next edge
    int                      req_count;         // frame requests so far
    int                      errors;
    int                      errors_at_start;
    int                      tests_run;
    int                      tests_failed;
    string                   test_name;

    sata_tl_buffers u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .h2d_data            (h2d_data),
        .h2d_type            (h2d_type),
        .h2d_valid           (h2d_valid),
        .h2d_ready           (h2d_ready),
        .ll_h2d_data         (ll_h2d_data),
        .ll_h2d_last         (ll_h2d_last),
        .ll_h2d_valid        (ll_h2d_valid),
        .ll_h2d_strobe       (ll_h2d_strobe),
        .ll_frame_req        (ll_frame_req),
        .ll_frame_busy       (ll_frame_busy),
        .ll_d2h_data         (ll_d2h_data),
        .ll_d2h_valid        (ll_d2h_valid),
        .ll_d2h_busy         (ll_d2h_busy),
        .ll_incom_start      (ll_incom_start),
        .ll_incom_done       (ll_incom_done),
        .ll_incom_invalidate (ll_incom_invalidate),
        .d2h_data            (d2h_data),
        .d2h_type            (d2h_type),
        .d2h_valid           (d2h_valid),
        .d2h_many            (d2h_many),
        .d2h_ready           (d2h_ready)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic check_eq(input string what, input logic [33:0] expected,
                            input logic [33:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic note_fault(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // one host entry per call, valid stays high until the caller drops it
    task automatic host_write(input sata_tl_pkg::h2d_type_t kind, input sata_tl_pkg::word_t data);
        @(posedge clk);
        h2d_type  <= kind;
        h2d_data  <= data;
        h2d_valid <= 1'b1;
        exp_h2d_data.push_back(data);
        exp_h2d_last.push_back(kind == sata_tl_pkg::h2d_fis_last);
    endtask

    // start pulse, n words, then done or invalidate
    task automatic link_fis(input int n, input bit bad);
        sata_tl_pkg::word_t w;
        @(posedge clk);
        ll_incom_start <= 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            ll_incom_start <= 1'b0;
            w = $urandom;
            ll_d2h_data  <= w;
            ll_d2h_valid <= 1'b1;
            exp_d2h_data.push_back(w);
            exp_d2h_type.push_back(i == 0 ? sata_tl_pkg::d2h_fis_head : sata_tl_pkg::d2h_fis_data);
            exp_d2h_chk.push_back(1'b1);
        end
        @(posedge clk);
        ll_incom_start      <= 1'b0;
        ll_d2h_valid        <= 1'b0;
        ll_incom_done       <= !bad;
        ll_incom_invalidate <= bad;
        @(posedge clk);
        ll_incom_done       <= 1'b0;
        ll_incom_invalidate <= 1'b0;
        if (n > 0) begin  // status entry only after words
            exp_d2h_data.push_back('0);
            exp_d2h_type.push_back(bad ? sata_tl_pkg::d2h_fis_err : sata_tl_pkg::d2h_fis_ok);
            exp_d2h_chk.push_back(1'b0);
        end
    endtask

    task automatic wait_req(input int target);
        int n;
        n = 0;
        while (req_count < target && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (req_count < target) begin
            note_fault("timed out waiting for a frame request");
        end
    endtask

    task automatic wait_h2d_drain();
        int n;
        n = 0;
        while (exp_h2d_data.size() != 0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (exp_h2d_data.size() != 0) begin
            note_fault("timed out waiting for the link side to drain");
        end
    endtask

    task automatic wait_d2h_drain();
        int n;
        n = 0;
        while ((exp_d2h_type.size() != 0 || d2h_valid) && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (exp_d2h_type.size() != 0) begin
            note_fault("timed out waiting for the host side to drain");
        end
    endtask

    // reference occupancy and request count, updated on the clock edge
    always @(posedge clk) begin
        if (rst) begin
            d2h_fill_model <= '0;
            got_word       <= 1'b0;
            status_due     <= 1'b0;
            req_count      <= 0;
        end else begin
            if (ll_incom_start || ll_incom_done || ll_incom_invalidate) begin
                got_word <= 1'b0;
            end else if (ll_d2h_valid) begin
                got_word <= 1'b1;
            end
            status_due     <= (ll_incom_done || ll_incom_invalidate) && got_word;
            d2h_fill_model <= d2h_fill_model
                            + sata_tl_pkg::fifo_fill_t'(ll_d2h_valid || status_due)
                            - sata_tl_pkg::fifo_fill_t'(d2h_valid && d2h_ready);
            if (ll_frame_req) begin
                req_count <= req_count + 1;
            end
        end
    end

    a_many_level: assert property (@(posedge clk) disable iff (rst)
        d2h_many == (d2h_fill_model >= sata_tl_pkg::d2h_many_fill))
    else begin
        errors++;
        $display("** Error %s d2h_many: expected %0b, actual %0b", test_name,
                 $sampled(d2h_fill_model >= sata_tl_pkg::d2h_many_fill), $sampled(d2h_many));
    end

    a_busy_level: assert property (@(posedge clk) disable iff (rst)
        ll_d2h_busy == (d2h_fill_model >= sata_tl_pkg::d2h_busy_fill))
    else begin
        errors++;
        $display("** Error %s ll_d2h_busy: expected %0b, actual %0b", test_name,
                 $sampled(d2h_fill_model >= sata_tl_pkg::d2h_busy_fill), $sampled(ll_d2h_busy));
    end

    // word is consumed on the coming edge
    always @(negedge clk) begin
        if (!rst && ll_h2d_valid && ll_h2d_strobe) begin
            if (exp_h2d_data.size() == 0) begin
                note_fault("link side delivered a word that was never written");
            end else begin
                check_eq("ll_h2d_data", 34'(exp_h2d_data.pop_front()), 34'(ll_h2d_data));
                check_eq("ll_h2d_last", 34'(exp_h2d_last.pop_front()), 34'(ll_h2d_last));
            end
        end
    end

    always @(negedge clk) begin : d2h_monitor
        bit                 chk;
        sata_tl_pkg::word_t exp_word;
        if (!rst && d2h_valid && d2h_ready) begin
            if (exp_d2h_type.size() == 0) begin
                note_fault("host side received an entry that was never expected");
            end else begin
                chk      = exp_d2h_chk.pop_front();
                exp_word = exp_d2h_data.pop_front();
                check_eq("d2h_type", 34'(exp_d2h_type.pop_front()), 34'(d2h_type));
                if (chk) begin  // status data is don't care
                    check_eq("d2h_data", 34'(exp_word), 34'(d2h_data));
                end
            end
        end
    end

    initial begin
        int base;
        int seed_ret;
        seed_ret            = $urandom(32'h57c3749d);
        clk                 = 1'b0;
        rst                 = 1'b1;
        h2d_data            = '0;
        h2d_type            = sata_tl_pkg::h2d_fis_data;
        h2d_valid           = 1'b0;
        ll_h2d_strobe       = 1'b0;
        ll_frame_busy       = 1'b0;
        ll_d2h_data         = '0;
        ll_d2h_valid        = 1'b0;
        ll_incom_start      = 1'b0;
        ll_incom_done       = 1'b0;
        ll_incom_invalidate = 1'b0;
        d2h_ready           = 1'b1;
        errors              = 0;
        tests_run           = 0;
        tests_failed        = 0;
        test_name           = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        check_eq("ll_frame_req", 34'(1'b0), 34'(ll_frame_req));
        check_eq("h2d_ready", 34'(1'b1), 34'(h2d_ready));
        check_eq("d2h_valid", 34'(1'b0), 34'(d2h_valid));
        check_eq("ll_h2d_valid", 34'(1'b0), 34'(ll_h2d_valid));
        check_eq("d2h_many", 34'(1'b0), 34'(d2h_many));
        check_eq("ll_d2h_busy", 34'(1'b0), 34'(ll_d2h_busy));
        end_test();

        begin_test("short_fis");
        @(posedge clk);
        ll_h2d_strobe <= 1'b1;  // link takes every word
        base = req_count;
        host_write(sata_tl_pkg::h2d_fis_head, $urandom);
        repeat (5) host_write(sata_tl_pkg::h2d_fis_data, $urandom);
        host_write(sata_tl_pkg::h2d_fis_last, $urandom);
        @(posedge clk);
        h2d_valid <= 1'b0;      // last word goes in on this edge
        @(negedge clk);
        check_eq("ll_frame_req after last", 34'(1'b1), 34'(ll_frame_req));
        wait_h2d_drain();
        check_eq("frame requests", 34'(base + 1), 34'(req_count));
        end_test();

        begin_test("long_fis_busy");
        @(posedge clk);
        ll_h2d_strobe <= 1'b0;
        ll_frame_busy <= 1'b1;
        base = req_count;
        host_write(sata_tl_pkg::h2d_fis_head, $urandom);
        repeat (70) host_write(sata_tl_pkg::h2d_fis_data, $urandom);
        @(posedge clk);
        h2d_valid <= 1'b0;
        @(negedge clk);
        check_eq("requests while busy", 34'(base), 34'(req_count));
        @(posedge clk);
        ll_frame_busy <= 1'b0;
        wait_req(base + 1);     // must come with no last word written
        host_write(sata_tl_pkg::h2d_fis_last, $urandom);
        @(posedge clk);
        h2d_valid     <= 1'b0;
        ll_h2d_strobe <= 1'b1;
        wait_h2d_drain();
        check_eq("frame requests", 34'(base + 1), 34'(req_count));
        end_test();

        begin_test("good_receive");
        link_fis(4, 1'b0);
        wait_d2h_drain();
        end_test();

        begin_test("bad_receive");
        link_fis(4, 1'b1);
        wait_d2h_drain();
        link_fis(0, 1'b0);      // empty FIS, no status expected
        repeat (4) @(negedge clk);
        check_eq("d2h_valid after empty FIS", 34'(1'b0), 34'(d2h_valid));
        end_test();

        begin_test("backpressure");
        @(posedge clk);
        d2h_ready <= 1'b0;
        link_fis(70, 1'b0);     // levels watched by the assertions
        @(negedge clk);
        check_eq("ll_d2h_busy when held", 34'(1'b1), 34'(ll_d2h_busy));
        @(posedge clk);
        d2h_ready <= 1'b1;
        wait_d2h_drain();
        check_eq("d2h_many after drain", 34'(1'b0), 34'(d2h_many));
        @(posedge clk);
        ll_h2d_strobe <= 1'b0;
        repeat (503) host_write(sata_tl_pkg::h2d_fis_data, $urandom);
        @(posedge clk);
        h2d_valid <= 1'b0;
        @(negedge clk);
        check_eq("h2d_ready at 503", 34'(1'b1), 34'(h2d_ready));
        host_write(sata_tl_pkg::h2d_fis_data, $urandom);
        @(posedge clk);
        h2d_valid <= 1'b0;
        @(negedge clk);
        check_eq("h2d_ready at 504", 34'(1'b0), 34'(h2d_ready));
        @(posedge clk);
        ll_h2d_strobe <= 1'b1;
        wait_h2d_drain();
        check_eq("h2d_ready after drain", 34'(1'b1), 34'(h2d_ready));
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
src/sata_tl_pkg.sv
src/fifo_ctrl.sv
src/fifo_mem.sv
src/h2d_frame_sched.sv
src/d2h_fis_tagger.sv
src/sata_tl_buffers.sv
bench/tb_sata_tl_buffers.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_sata_tl_buffers -f all.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
